/* sim.f */
+incdir+include
src/spi_bus_pkg.sv
src/csr_map_pkg.sv
src/spi_peripheral.sv
src/register_bank.sv
src/byte_fifo.sv
src/spi_subsystem_top.sv
verif/spi_subsystem_tb.sv

/* run_sim.sh */
#!/bin/sh
# Build with Verilator, run, then judge the run from its log
cd "$(dirname "$0")" || exit 1
rm -rf obj_dir sim.log
verilator --binary --timing --assert -Wno-fatal -f sim.f \
    --top-module spi_subsystem_tb --Mdir obj_dir -o spi_sim \
    && ./obj_dir/spi_sim > sim.log 2>&1 \
    || echo "Build or simulation returned an error"
[ -f sim.log ] && cat sim.log
grep -qx "TESTBENCH PASSED" sim.log && echo "Simulation result: pass" && exit 0 \
    || { echo "Simulation result: fail"; exit 1; }

/* verif/spi_subsystem_tb.sv */
`timescale 1ns/1ps

`include "spi_macros.svh"

module spi_subsystem_tb;

    typedef logic [7:0] byte_q_t [$];

    localparam int EDGE_LIMIT = 40;   // Wakeups allowed while waiting for one edge

    // DUT inputs and output
    logic spi_resetn;
    logic spi_select;
    logic spi_clock_in;
    logic spi_data_in;
    logic spi_data_out;

    logic poll_tick;                  // Time base for bounded waits

    // Stimulus and reference state
    logic [31:0] lfsr_state;
    logic [7:0]  scratch_model [4];
    byte_q_t     fifo_model;          // Expected FIFO contents, head first
    int          check_count;
    int          error_count;
    logic        timed_out;

    spi_subsystem_top dut_i (
        .spi_resetn   (spi_resetn),
        .spi_select   (spi_select),
        .spi_clock_in (spi_clock_in),
        .spi_data_in  (spi_data_in),
        .spi_data_out (spi_data_out)
    );

    always #4 spi_clock_in = ~spi_clock_in;   // 8 ns period
    always #1 poll_tick = ~poll_tick;

    // Fibonacci LFSR with taps 32 22 2 1
    function automatic logic [31:0] lfsr_step(input logic [31:0] state);
        logic feedback;
        feedback = state[31] ^ state[21] ^ state[1] ^ state[0];
        return {state[30:0], feedback};
    endfunction

    // One step per bit taken
    function automatic logic [7:0] random_byte();
        logic [7:0] value;
        value = '0;
        for (int i = 0; i < 8; i++) begin
            lfsr_state = lfsr_step(lfsr_state);
            value      = {value[6:0], lfsr_state[0]};
        end
        return value;
    endfunction

    function automatic byte_q_t random_bytes(input int count);
        byte_q_t q;
        q = {};
        for (int i = 0; i < count; i++) begin
            q.push_back(random_byte());
        end
        return q;
    endfunction

    function automatic byte_q_t zero_bytes(input int count);
        byte_q_t q;
        q = {};
        for (int i = 0; i < count; i++) begin
            q.push_back(8'h00);
        end
        return q;
    endfunction

    // Rising edge of the SPI clock within a bounded number of poll_tick wakeups
    task automatic wait_rising();
        int   wakeups;
        logic last;
        if (timed_out) begin
            return;                               // Run is already lost
        end
        wakeups = 0;
        last    = spi_clock_in;
        while (!(last === 1'b0 && spi_clock_in === 1'b1)) begin
            if (wakeups >= EDGE_LIMIT) begin
                $display("ERROR at %0t: spi_clock_in stopped, no rising edge seen", $time);
                timed_out = 1'b1;
                return;
            end
            last = spi_clock_in;
            @(spi_clock_in or poll_tick);
            wakeups++;
        end
    endtask

    task automatic check_value(input logic [31:0] actual, input logic [31:0] expected,
                               input string msg);
        if (timed_out) begin
            return;
        end
        check_count++;
        if (actual !== expected) begin
            error_count++;
            $display("CHECK FAILED at %0t: %s, got 0x%0h, expected 0x%0h",
                     $time, msg, actual, expected);
        end
    endtask

    // Mode 0 transaction with nbits data bits after the address
    // Select stays low one edge past the last bit so the last write strobe fires
    task automatic spi_transfer(input logic [7:0] addr, input byte_q_t tx, input int nbits,
                                output byte_q_t rx);
        int         total;
        int         k;
        logic [7:0] cur;
        logic [7:0] tx_byte;
        rx    = {};
        cur   = '0;
        total = 8 + nbits;                        // Edge of the last sampled bit
        wait_rising();
        spi_select  <= 1'b0;
        spi_data_in <= addr[7];
        for (int e = 1; e <= total + 1; e++) begin
            wait_rising();
            if (e >= 9 && e <= total) begin
                cur = {cur[6:0], spi_data_out};   // Launched on the last falling edge
                if ((e - 8) % 8 == 0) begin
                    rx.push_back(cur);
                end
            end
            if (e < 8) begin
                spi_data_in <= addr[7 - e];
            end else if (e < total) begin
                k       = e - 8;                  // Stream bit sampled on the next edge
                tx_byte = (k / 8 < tx.size()) ? tx[k / 8] : 8'h00;
                spi_data_in <= tx_byte[7 - (k % 8)];
            end else if (e == total) begin
                spi_data_in <= 1'b0;
            end else begin
                spi_select <= 1'b1;               // Cuts a partial byte short
            end
        end
        repeat (2) begin
            wait_rising();
        end
    endtask

    task automatic apply_reset();
        wait_rising();
        spi_resetn <= 1'b0;
        repeat (8) begin
            wait_rising();
        end
        spi_resetn <= 1'b1;
        repeat (2) begin
            wait_rising();
        end
    endtask

    // Only completed bytes reach the FIFO and extra ones drop when full
    task automatic push_bytes(input byte_q_t tx, input int nbits);
        byte_q_t rx;
        for (int i = 0; i < nbits / 8; i++) begin
            if (fifo_model.size() < `FIFO_DEPTH) begin
                fifo_model.push_back(tx[i]);
            end
        end
        spi_transfer(`ADDR_FIFO_PUSH, tx, nbits, rx);
    endtask

    task automatic pop_and_check(input int count, input string tag);
        byte_q_t    rx;
        logic [7:0] expected;
        spi_transfer(`ADDR_FIFO_POP, zero_bytes(count), 8 * count, rx);
        foreach (rx[i]) begin
            if (fifo_model.size() > 0) begin
                expected = fifo_model.pop_front();
            end else begin
                expected = 8'h00;                 // Empty FIFO answers zero
            end
            check_value(rx[i], expected, $sformatf("%s pop byte %0d", tag, i));
        end
    endtask

    task automatic check_level(input int expected, input string tag);
        byte_q_t rx;
        spi_transfer(`ADDR_FIFO_LEVEL, zero_bytes(1), 8, rx);
        check_value(rx[0], expected, {tag, " level"});
    endtask

    task automatic test_chip_id();
        byte_q_t rx;
        spi_transfer(`ADDR_CHIP_ID, zero_bytes(3), 24, rx);
        foreach (rx[i]) begin
            check_value(rx[i], `CHIP_ID, $sformatf("chip id byte %0d", i));
        end
        spi_transfer(8'h5a, zero_bytes(2), 16, rx);     // Nobody answers here
        foreach (rx[i]) begin
            check_value(rx[i], 8'h00, $sformatf("unmapped byte %0d", i));
        end
    endtask

    task automatic test_scratch();
        byte_q_t tx;
        byte_q_t rx;
        tx = random_bytes(6);
        foreach (tx[i]) begin
            scratch_model[i % 4] = tx[i];               // Later positions overwrite
        end
        spi_transfer(`ADDR_SCRATCH_WR, tx, 48, rx);
        spi_transfer(`ADDR_SCRATCH_RD, zero_bytes(5), 40, rx);
        foreach (rx[i]) begin
            check_value(rx[i], scratch_model[i % 4], $sformatf("scratch read byte %0d", i));
        end
    endtask

    task automatic test_fifo_order();
        push_bytes(random_bytes(5), 40);
        check_level(5, "after five pushes");
        pop_and_check(5, "in order");
        check_level(0, "after five pops");
    endtask

    task automatic test_fifo_overflow();
        push_bytes(random_bytes(`FIFO_DEPTH + 3), 8 * (`FIFO_DEPTH + 3));
        check_level(`FIFO_DEPTH, "overfilled");
        pop_and_check(`FIFO_DEPTH + 2, "drain past empty");
        check_level(0, "after drain");
    endtask

    // Select rises four bits into the fourth byte
    task automatic test_push_abort();
        push_bytes(random_bytes(4), 3 * 8 + 4);
        check_level(3, "after aborted push");
        pop_and_check(3, "aborted push");
        check_level(0, "after aborted push drain");
    endtask

    initial begin
        spi_clock_in = 1'b0;
        poll_tick    = 1'b0;
        spi_resetn   = 1'b1;      // Falls on the first edge for a clean async reset
        spi_select   = 1'b1;
        spi_data_in  = 1'b0;
        lfsr_state   = 32'hfb88;
        check_count  = 0;
        error_count  = 0;
        timed_out    = 1'b0;
        fifo_model   = {};
        foreach (scratch_model[i]) begin
            scratch_model[i] = 8'h00;
        end

        apply_reset();
        test_chip_id();
        test_scratch();
        test_fifo_order();
        test_fifo_overflow();
        test_push_abort();

        $display("Checks: %0d, errors: %0d, timeouts: %0d",
                 check_count, error_count, timed_out);
        if (error_count == 0 && !timed_out) begin
            $display("TESTBENCH PASSED");
        end else begin
            $display("TESTBENCH FAILED");
        end
        $finish;
    end

endmodule

/* src/spi_subsystem_top.sv */
`timescale 1ns/1ps

module spi_subsystem_top (
    input  logic spi_resetn,      // Asynchronous, active low
    input  logic spi_select,      // Active low
    input  logic spi_clock_in,
    input  logic spi_data_in,
    output logic spi_data_out
);
    import spi_bus_pkg::*;
    import csr_map_pkg::*;

    // Strobe bus from the peripheral
    reg_addr_t   address;
    spi_byte_t   wr_data;
    byte_count_t rd_byte_count;
    byte_count_t wr_byte_count;
    logic        data_wr_en;
    logic        data_rd_en;

    // Read data, one source per block
    spi_byte_t   rd_data;
    spi_byte_t   bank_rd_data;
    spi_byte_t   fifo_rd_data;

    // Each block answers zero off its own addresses
    assign rd_data = bank_rd_data | fifo_rd_data;

    spi_peripheral peripheral_i (
        .spi_resetn    (spi_resetn),
        .spi_select    (spi_select),
        .spi_clock_in  (spi_clock_in),
        .spi_data_in   (spi_data_in),
        .spi_data_out  (spi_data_out),
        .address       (address),
        .wr_data       (wr_data),
        .rd_byte_count (rd_byte_count),
        .wr_byte_count (wr_byte_count),
        .data_wr_en    (data_wr_en),
        .data_rd_en    (data_rd_en),
        .rd_data       (rd_data)
    );

    register_bank register_bank_i (
        .spi_clock_in  (spi_clock_in),
        .spi_resetn    (spi_resetn),
        .address       (address),
        .wr_data       (wr_data),
        .rd_byte_count (rd_byte_count),
        .wr_byte_count (wr_byte_count),
        .data_wr_en    (data_wr_en),
        .rd_data       (bank_rd_data)
    );

    byte_fifo byte_fifo_i (
        .spi_clock_in  (spi_clock_in),
        .spi_resetn    (spi_resetn),
        .address       (address),
        .wr_data       (wr_data),
        .data_wr_en    (data_wr_en),
        .data_rd_en    (data_rd_en),
        .rd_data       (fifo_rd_data)
    );

endmodule

/* src/byte_fifo.sv */
`timescale 1ns/1ps

`include "spi_macros.svh"

module byte_fifo (
    input  logic                   spi_clock_in,
    input  logic                   spi_resetn,     // Global only
    input  csr_map_pkg::reg_addr_t address,
    input  spi_bus_pkg::spi_byte_t wr_data,
    input  logic                   data_wr_en,     // Push strobe at push address
    input  logic                   data_rd_en,     // Pop strobe at pop address
    output spi_bus_pkg::spi_byte_t rd_data
);
    import spi_bus_pkg::*;
    import csr_map_pkg::*;

    spi_byte_t   mem [`FIFO_DEPTH];   // Byte storage
    fifo_ptr_t   wr_ptr;
    fifo_ptr_t   rd_ptr;               // Points at the head
    fifo_level_t level;
    logic        full;
    logic        empty;
    logic        push_req;
    logic        pop_req;
    logic        push;
    logic        pop;

    assign full  = (level == fifo_level_t'(`FIFO_DEPTH));
    assign empty = (level == '0);

    // Requests from the SPI side
    assign push_req = data_wr_en && (address == `ADDR_FIFO_PUSH);
    assign pop_req  = data_rd_en && (address == `ADDR_FIFO_POP);

    assign push = push_req && !full;    // Dropped when full
    assign pop  = pop_req && !empty;    // Ignored when empty

    // Data store
    always_ff @(posedge spi_clock_in) begin
        if (push) begin
            mem[wr_ptr] <= wr_data;
        end
    end

    // Pointers and level
    // Pointers wrap since depth is a power of two
    always_ff @(posedge spi_clock_in or negedge spi_resetn) begin
        if (!spi_resetn) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            level  <= '0;
        end else begin
            if (push) begin
                wr_ptr <= wr_ptr + 1'b1;
            end
            if (pop) begin
                rd_ptr <= rd_ptr + 1'b1;   // Next head ready for next byte
            end
            case ({push, pop})
                2'b10:   level <= level + 1'b1;
                2'b01:   level <= level - 1'b1;
                default: level <= level;     // Idle or both
            endcase
        end
    end

    // Readback
    always_comb begin
        case (address)
            `ADDR_FIFO_POP:   rd_data = empty ? '0 : mem[rd_ptr];
            `ADDR_FIFO_LEVEL: rd_data = spi_byte_t'(level);
            default:          rd_data = '0;
        endcase
    end

    // Level bound
    a_level_bound : assert property (
        @(posedge spi_clock_in) disable iff (!spi_resetn)
        level <= fifo_level_t'(`FIFO_DEPTH)
    ) else $error("FIFO level above depth");

endmodule

/* src/register_bank.sv */
`timescale 1ns/1ps

`include "spi_macros.svh"

module register_bank (
    input  logic                     spi_clock_in,
    input  logic                     spi_resetn,      // Global only so state survives deselect
    input  csr_map_pkg::reg_addr_t   address,
    input  spi_bus_pkg::spi_byte_t   wr_data,
    input  spi_bus_pkg::byte_count_t rd_byte_count,
    input  spi_bus_pkg::byte_count_t wr_byte_count,
    input  logic                     data_wr_en,
    output spi_bus_pkg::spi_byte_t   rd_data          // Zero off our addresses
);
    import spi_bus_pkg::*;
    import csr_map_pkg::*;

    spi_byte_t      scratch [`SCRATCH_SIZE];
    scratch_index_t wr_idx;
    scratch_index_t rd_idx;
    logic           scratch_wr;

    // Byte position mod 4 picks the slot
    assign wr_idx = scratch_index_t'(wr_byte_count);
    assign rd_idx = scratch_index_t'(rd_byte_count);

    assign scratch_wr = data_wr_en && (address == `ADDR_SCRATCH_WR);

    // Scratch storage
    always_ff @(posedge spi_clock_in or negedge spi_resetn) begin
        if (!spi_resetn) begin
            for (int i = 0; i < `SCRATCH_SIZE; i++) begin
                scratch[i] <= '0;
            end
        end else if (scratch_wr) begin
            scratch[wr_idx] <= wr_data;
        end
    end

    // Readback
    // Sampled by the peripheral at each byte boundary
    always_comb begin
        case (address)
            `ADDR_CHIP_ID:    rd_data = `CHIP_ID;         // Same for every byte
            `ADDR_SCRATCH_RD: rd_data = scratch[rd_idx];
            default:          rd_data = '0;               // Let other blocks through
        endcase
    end

endmodule

/* src/spi_peripheral.sv */
`timescale 1ns/1ps

module spi_peripheral (
    input  logic                     spi_resetn,     // Global reset
    input  logic                     spi_select,     // Active low
    input  logic                     spi_clock_in,
    input  logic                     spi_data_in,    // From host
    output logic                     spi_data_out,   // To host
    output csr_map_pkg::reg_addr_t   address,        // Held after the address phase
    output spi_bus_pkg::spi_byte_t   wr_data,
    output spi_bus_pkg::byte_count_t rd_byte_count,  // Byte being shifted out
    output spi_bus_pkg::byte_count_t wr_byte_count,  // Byte being written
    output logic                     data_wr_en,
    output logic                     data_rd_en,
    input  spi_bus_pkg::spi_byte_t   rd_data         // ORed sub-peripheral data
);
    import spi_bus_pkg::*;

    logic       local_resetn;   // Also asserted while deselected
    bit_index_t bit_index;
    spi_byte_t  shift_reg;      // Shared between receive and transmit
    logic       addr_phase;
    logic       byte_start;     // First data bit of a byte
    logic       byte_last;      // Last data bit of a byte

    // Deselect acts as reset for all control state
    assign local_resetn = spi_resetn & ~spi_select;

    assign addr_phase = bit_index[3];                     // Indices 15..8
    assign byte_start = (bit_index == bit_index_t'(7));
    assign byte_last  = (bit_index == bit_index_t'(0));

    // Complete byte sits here for the cycle after its last bit
    assign wr_data = shift_reg;

    // Bit and byte bookkeeping on the sampling edge
    always_ff @(posedge spi_clock_in or negedge local_resetn) begin
        if (!local_resetn) begin
            bit_index     <= bit_index_t'(15);
            rd_byte_count <= '0;
            wr_byte_count <= '0;
            data_wr_en    <= 1'b0;
            data_rd_en    <= 1'b0;
        end else begin
            if (byte_last) begin
                bit_index     <= bit_index_t'(7);      // Next byte, no gap
                rd_byte_count <= rd_byte_count + 1'b1;
            end else begin
                bit_index <= bit_index - 1'b1;
            end

            data_wr_en <= byte_last;                          // Cycle after last bit
            data_rd_en <= (bit_index == bit_index_t'(1));     // During last bit

            // Trails rd_byte_count by one strobe
            if (data_wr_en) begin
                wr_byte_count <= rd_byte_count;
            end
        end
    end

    // Launch on the falling edge, mode 0
    always_ff @(negedge spi_clock_in or negedge local_resetn) begin
        if (!local_resetn) begin
            spi_data_out <= 1'b0;
        end else if (byte_start) begin
            spi_data_out <= rd_data[7];       // MSB straight from the block
        end else if (!addr_phase) begin
            spi_data_out <= shift_reg[7];
        end
    end

    // Sample on the rising edge
    // Address and data payload carry no reset
    always_ff @(posedge spi_clock_in) begin
        if (addr_phase) begin
            address <= {address[6:0], spi_data_in};          // MSB first
        end else if (byte_start) begin
            // Load the read byte minus the bit already launched
            shift_reg <= {rd_data[6:0], spi_data_in};
        end else begin
            shift_reg <= {shift_reg[6:0], spi_data_in};
        end
    end

    // Strobes mark different bit positions so cannot overlap
    a_strobes_exclusive : assert property (
        @(posedge spi_clock_in) disable iff (!local_resetn)
        !(data_wr_en && data_rd_en)
    ) else $error("write and read strobes high together");

    // No strobe may reach the blocks before the first data byte
    a_no_strobe_in_addr : assert property (
        @(posedge spi_clock_in) disable iff (!local_resetn)
        addr_phase |-> !(data_wr_en || data_rd_en)
    ) else $error("strobe during address phase");

endmodule

/* src/csr_map_pkg.sv */
// Types on the register side of the subsystem

`include "spi_macros.svh"

package csr_map_pkg;

    // Address selected by the first byte of a transaction
    typedef logic [7:0] reg_addr_t;

    // Index into the scratch bytes
    typedef logic [$clog2(`SCRATCH_SIZE)-1:0] scratch_index_t;

    // FIFO read and write pointers
    typedef logic [$clog2(`FIFO_DEPTH)-1:0] fifo_ptr_t;

    // Fill level, one bit wider so that full fits
    typedef logic [$clog2(`FIFO_DEPTH):0] fifo_level_t;

endpackage

/* src/spi_bus_pkg.sv */
// Types on the link side of the SPI peripheral

package spi_bus_pkg;

    // One byte as shifted on the wire
    // Address byte and data bytes share the width
    typedef logic [7:0] spi_byte_t;

    // Bit counter inside a transaction
    // 15..8 address phase
    // 7..0 data bits, rolls over for back-to-back bytes
    typedef logic [3:0] bit_index_t;

    // Data byte position within one transaction
    // Starts at 0 for the first byte after the address
    typedef logic [31:0] byte_count_t;

endpackage

/* include/spi_macros.svh */
`ifndef SPI_MACROS_SVH
`define SPI_MACROS_SVH

// Value returned for every data byte read at the ID address
`define CHIP_ID          8'h81

// Register bank addresses
`define ADDR_CHIP_ID     8'hDB
`define ADDR_SCRATCH_WR  8'h10   // Write scratch, indexed by byte position
`define ADDR_SCRATCH_RD  8'h11   // Read scratch, indexed by byte position

// Byte FIFO addresses
`define ADDR_FIFO_PUSH   8'h20
`define ADDR_FIFO_POP    8'h21
`define ADDR_FIFO_LEVEL  8'h22

// Sizes
`define FIFO_DEPTH       16      // Power of two, pointers wrap on their own
`define SCRATCH_SIZE     4       // Position mod 4 selects the byte

`endif
